//--- vliwPkg.sv
package vliwPkg;

    localparam int wordWidth = 32;
    localparam int slotWidth = 32;
    localparam int regIdxWidth = 5;
    localparam int imemAddrWidth = 8;
    localparam int dmemAddrWidth = 8;
    localparam int opcodeWidth = 6;

    // slot field positions
    localparam int opMsb = 31;
    localparam int opLsb = 26;
    localparam int rsMsb = 25;
    localparam int rsLsb = 21;
    localparam int rtMsb = 20;
    localparam int rtLsb = 16;
    localparam int rdMsb = 15;
    localparam int rdLsb = 11;
    localparam int immMsb = 15;
    localparam int immLsb = 0;

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [slotWidth-1:0] slot_t;
    // slot 0 sits in the low half
    typedef logic [2*slotWidth-1:0] bundle_t;
    typedef logic [regIdxWidth-1:0] regIdx_t;
    typedef logic [imemAddrWidth-1:0] imemAddr_t;
    typedef logic [dmemAddrWidth-1:0] dmemAddr_t;

    typedef enum logic [opcodeWidth-1:0] {
        OP_NOP  = 6'd0,
        OP_ADD  = 6'd1,
        OP_SUB  = 6'd2,
        OP_AND  = 6'd3,
        OP_OR   = 6'd4,
        OP_ADDI = 6'd5,
        OP_BEQ  = 6'd6,
        OP_J    = 6'd7,
        OP_OUT  = 6'd8,
        OP_LW   = 6'd9,
        OP_SW   = 6'd10
    } opcode_t;

    typedef enum logic [1:0] {
        FWD_REG   = 2'd0,
        FWD_ALU_M = 2'd1,
        FWD_MEM_W = 2'd2
    } fwdSel_t;

    localparam bundle_t nopBundle = '0;

    // execute operand after bypass from memory or writeback
    function automatic word_t pickOperand(fwdSel_t sel, word_t regVal,
                                          word_t aluM, word_t memW);
        case (sel)
            FWD_ALU_M: return aluM;
            FWD_MEM_W: return memW;
            default:   return regVal;
        endcase
    endfunction

endpackage

//--- regFile.sv
`timescale 1ns/1ps

module regFile
    import vliwPkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  regIdx_t raddr0,
    input  regIdx_t raddr1,
    input  regIdx_t raddr2,
    input  regIdx_t raddr3,
    input  logic    we0,
    input  regIdx_t waddr0,
    input  word_t   wdata0,
    input  logic    we1,
    input  regIdx_t waddr1,
    input  word_t   wdata1,
    output word_t   rdata0,
    output word_t   rdata1,
    output word_t   rdata2,
    output word_t   rdata3
);

    word_t regs [2**regIdxWidth];

    // port 0 carries the younger write and wins a tie
    function automatic word_t readPort(regIdx_t addr, word_t stored);
        if (addr == '0) begin
            return '0;
        end else if (we0 && waddr0 == addr) begin
            return wdata0;
        end else if (we1 && waddr1 == addr) begin
            return wdata1;
        end
        return stored;
    endfunction

    always_comb begin
        rdata0 = readPort(raddr0, regs[raddr0]);
        rdata1 = readPort(raddr1, regs[raddr1]);
        rdata2 = readPort(raddr2, regs[raddr2]);
        rdata3 = readPort(raddr3, regs[raddr3]);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 2**regIdxWidth; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we1 && waddr1 != '0) begin
                regs[waddr1] <= wdata1;
            end
            if (we0 && waddr0 != '0) begin
                regs[waddr0] <= wdata0;
            end
        end
    end

endmodule

//--- bundleFetch.sv
`timescale 1ns/1ps

module bundleFetch
    import vliwPkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      run,
    input  logic      stall,
    input  logic      flush,
    input  logic      branchTaken,
    input  imemAddr_t branchTarget,
    input  logic      imemWe,
    input  imemAddr_t imemAddr,
    input  bundle_t   imemData,
    output bundle_t   bundle,
    output imemAddr_t bundlePc
);

    bundle_t   imem [2**imemAddrWidth];
    imemAddr_t pc;
    logic      advance;

    assign advance = run && !stall;

    // program load port
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (advance) begin
            pc <= pc + imemAddr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            bundle   <= nopBundle;
            bundlePc <= '0;
        end else if (advance) begin
            bundle   <= imem[pc];
            bundlePc <= pc;
        end else if (!stall) begin
            // idle fetch feeds bubbles
            bundle <= nopBundle;
        end
    end

endmodule

//--- bundleDecode.sv
`timescale 1ns/1ps

module bundleDecode
    import vliwPkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  bundle_t   bundle,
    input  imemAddr_t bundlePc,
    input  logic      stall,
    input  logic      stallEx,
    input  logic      flush,
    input  logic      we0,
    input  regIdx_t   waddr0,
    input  word_t     wdata0,
    input  logic      we1,
    input  regIdx_t   waddr1,
    input  word_t     wdata1,
    output opcode_t   exOp0,
    output regIdx_t   exRs0,
    output regIdx_t   exRt0,
    output regIdx_t   exDst0,
    output word_t     exImm0,
    output word_t     exA0,
    output word_t     exB0,
    output opcode_t   exOp1,
    output regIdx_t   exRs1,
    output regIdx_t   exRt1,
    output regIdx_t   exDst1,
    output word_t     exImm1,
    output word_t     exA1,
    output word_t     exB1,
    output imemAddr_t exPc
);

    slot_t slot0;
    slot_t slot1;
    word_t rdata0;
    word_t rdata1;
    word_t rdata2;
    word_t rdata3;

    function automatic opcode_t opOf(slot_t s);
        return opcode_t'(s[opMsb:opLsb]);
    endfunction

    function automatic word_t immOf(slot_t s);
        return {{(wordWidth - immMsb + immLsb - 1){s[immMsb]}}, s[immMsb:immLsb]};
    endfunction

    // ALU ops write rd, ADDI and LW write rt
    function automatic regIdx_t destOf(slot_t s);
        case (opOf(s))
            OP_ADD, OP_SUB, OP_AND, OP_OR: return s[rdMsb:rdLsb];
            OP_ADDI, OP_LW:                return s[rtMsb:rtLsb];
            default:                       return '0;
        endcase
    endfunction

    assign slot0 = bundle[slotWidth-1:0];
    assign slot1 = bundle[2*slotWidth-1:slotWidth];

    regFile regs0 (
        .clk   (clk),
        .rstn  (rstn),
        .raddr0(slot0[rsMsb:rsLsb]),
        .raddr1(slot0[rtMsb:rtLsb]),
        .raddr2(slot1[rsMsb:rsLsb]),
        .raddr3(slot1[rtMsb:rtLsb]),
        .we0   (we0),
        .waddr0(waddr0),
        .wdata0(wdata0),
        .we1   (we1),
        .waddr1(waddr1),
        .wdata1(wdata1),
        .rdata0(rdata0),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .rdata3(rdata3)
    );

    // load-use bubble unless execute is held for the output port
    always_ff @(posedge clk) begin
        if (!rstn || flush || (stall && !stallEx)) begin
            exOp0  <= OP_NOP;
            exDst0 <= '0;
            exOp1  <= OP_NOP;
            exDst1 <= '0;
        end else if (!stallEx) begin
            exOp0  <= opOf(slot0);
            exDst0 <= destOf(slot0);
            exOp1  <= opOf(slot1);
            exDst1 <= destOf(slot1);
        end
    end

    always_ff @(posedge clk) begin
        if (!stallEx) begin
            exRs0  <= slot0[rsMsb:rsLsb];
            exRt0  <= slot0[rtMsb:rtLsb];
            exImm0 <= immOf(slot0);
            exA0   <= rdata0;
            exB0   <= rdata1;
            exRs1  <= slot1[rsMsb:rsLsb];
            exRt1  <= slot1[rtMsb:rtLsb];
            exImm1 <= immOf(slot1);
            exA1   <= rdata2;
            exB1   <= rdata3;
            exPc   <= bundlePc;
        end
    end

endmodule

//--- hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit
    import vliwPkg::*;
(
    input  regIdx_t decRs0,
    input  regIdx_t decRt0,
    input  regIdx_t decRs1,
    input  regIdx_t decRt1,
    input  opcode_t exOp0,
    input  regIdx_t exRs0,
    input  regIdx_t exRt0,
    input  opcode_t exOp1,
    input  regIdx_t exRs1,
    input  regIdx_t exRt1,
    input  regIdx_t exDst1,
    input  logic    aluWe,
    input  regIdx_t aluRd,
    input  logic    memWe,
    input  regIdx_t memRd,
    input  logic    outValid,
    input  logic    outReady,
    input  logic    branchTaken,
    output logic    stallFront,
    output logic    stallEx,
    output logic    flush,
    output fwdSel_t fwdSelA0,
    output fwdSel_t fwdSelB0,
    output fwdSel_t fwdSelA1,
    output fwdSel_t fwdSelB1
);

    logic loadUse;
    logic outStall;

    // slot 0 in memory is younger than slot 1 in writeback
    function automatic fwdSel_t srcSel(regIdx_t src, logic aWe, regIdx_t aRd,
                                       logic mWe, regIdx_t mRd);
        if (src == '0) begin
            return FWD_REG;
        end else if (aWe && aRd == src) begin
            return FWD_ALU_M;
        end else if (mWe && mRd == src) begin
            return FWD_MEM_W;
        end
        return FWD_REG;
    endfunction

    assign fwdSelA0 = srcSel(exRs0, aluWe, aluRd, memWe, memRd);
    assign fwdSelB0 = srcSel(exRt0, aluWe, aluRd, memWe, memRd);
    assign fwdSelA1 = srcSel(exRs1, aluWe, aluRd, memWe, memRd);
    assign fwdSelB1 = srcSel(exRt1, aluWe, aluRd, memWe, memRd);

    // load data only reaches execute from writeback
    assign loadUse = exOp1 == OP_LW && exDst1 != '0
                     && (exDst1 == decRs0 || exDst1 == decRt0
                         || exDst1 == decRs1 || exDst1 == decRt1);

    // output register full and the next OUT waiting
    assign outStall = exOp0 == OP_OUT && outValid && !outReady;

    assign stallFront = loadUse || outStall;
    assign stallEx    = outStall;
    assign flush      = branchTaken;

endmodule

//--- aluSlot.sv
`timescale 1ns/1ps

module aluSlot
    import vliwPkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  opcode_t   exOp,
    input  regIdx_t   exDst,
    input  word_t     exImm,
    input  word_t     exA,
    input  word_t     exB,
    input  imemAddr_t exPc,
    input  fwdSel_t   fwdSelA,
    input  fwdSel_t   fwdSelB,
    input  word_t     loadData,
    input  logic      stall,
    input  logic      outReady,
    output logic      aluWe,
    output regIdx_t   aluRd,
    output word_t     aluResult,
    output logic      branchTaken,
    output imemAddr_t branchTarget,
    output logic      outValid,
    output word_t     outData
);

    word_t srcA;
    word_t srcB;
    word_t holdA;
    word_t holdB;
    word_t result;
    logic  holding;
    logic  writes;

    // bypass sources drain during a hold, so operands are kept here
    assign srcA = holding ? holdA : pickOperand(fwdSelA, exA, aluResult, loadData);
    assign srcB = holding ? holdB : pickOperand(fwdSelB, exB, aluResult, loadData);

    always_comb begin
        writes = 1'b1;
        case (exOp)
            OP_ADD:  result = srcA + srcB;
            OP_SUB:  result = srcA - srcB;
            OP_AND:  result = srcA & srcB;
            OP_OR:   result = srcA | srcB;
            OP_ADDI: result = srcA + exImm;
            default: begin
                result = '0;
                writes = 1'b0;
            end
        endcase
    end

    assign branchTaken  = (exOp == OP_BEQ && srcA == srcB) || exOp == OP_J;
    assign branchTarget = exOp == OP_J ? exImm[imemAddrWidth-1:0]
                        : exPc + imemAddr_t'(1) + exImm[imemAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            holding <= 1'b0;
        end else begin
            holding <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            holdA <= srcA;
            holdB <= srcB;
        end
    end

    // memory-stage register, bubble while execute holds
    always_ff @(posedge clk) begin
        if (!rstn || stall) begin
            aluWe <= 1'b0;
        end else begin
            aluWe <= writes && exDst != '0;
        end
    end

    always_ff @(posedge clk) begin
        aluRd     <= exDst;
        aluResult <= result;
    end

    // no stall means the register is empty or being emptied
    always_ff @(posedge clk) begin
        if (!rstn) begin
            outValid <= 1'b0;
        end else if (exOp == OP_OUT && !stall) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (exOp == OP_OUT && !stall) begin
            outData <= srcA;
        end
    end

endmodule

//--- memSlot.sv
`timescale 1ns/1ps

module memSlot
    import vliwPkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  opcode_t exOp,
    input  regIdx_t exDst,
    input  word_t   exImm,
    input  word_t   exA,
    input  word_t   exB,
    input  fwdSel_t fwdSelA,
    input  fwdSel_t fwdSelB,
    input  word_t   aluResult,
    input  logic    stall,
    output logic    memWe,
    output regIdx_t memRd,
    output word_t   loadData
);

    word_t     dmem [2**dmemAddrWidth];
    word_t     srcA;
    word_t     srcB;
    word_t     holdA;
    word_t     holdB;
    word_t     addrSum;
    word_t     readWord;
    dmemAddr_t addr;
    logic      holding;
    logic      loadM;
    regIdx_t   rdM;

    assign srcA = holding ? holdA : pickOperand(fwdSelA, exA, aluResult, loadData);
    assign srcB = holding ? holdB : pickOperand(fwdSelB, exB, aluResult, loadData);

    // word address, upper sum bits ignored
    assign addrSum = srcA + exImm;
    assign addr    = addrSum[dmemAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            holding <= 1'b0;
        end else begin
            holding <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            holdA <= srcA;
            holdB <= srcB;
        end
    end

    // store once, when the bundle leaves execute
    always_ff @(posedge clk) begin
        if (exOp == OP_SW && !stall) begin
            dmem[addr] <= srcB;
        end
        readWord <= dmem[addr];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            loadM <= 1'b0;
            memWe <= 1'b0;
        end else begin
            loadM <= exOp == OP_LW && exDst != '0 && !stall;
            memWe <= loadM;
        end
    end

    always_ff @(posedge clk) begin
        rdM      <= exDst;
        memRd    <= rdM;
        loadData <= readWord;
    end

endmodule

//--- vliwCore.sv
`timescale 1ns/1ps

module vliwCore
    import vliwPkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      imemWe,
    input  imemAddr_t imemAddr,
    input  bundle_t   imemData,
    input  logic      run,
    output logic      outValid,
    output word_t     outData,
    input  logic      outReady
);

    bundle_t   fdBundle;
    imemAddr_t fdPc;
    opcode_t   exOp0;
    opcode_t   exOp1;
    regIdx_t   exRs0;
    regIdx_t   exRt0;
    regIdx_t   exDst0;
    regIdx_t   exRs1;
    regIdx_t   exRt1;
    regIdx_t   exDst1;
    word_t     exImm0;
    word_t     exA0;
    word_t     exB0;
    word_t     exImm1;
    word_t     exA1;
    word_t     exB1;
    imemAddr_t exPc;
    logic      stallFront;
    logic      stallEx;
    logic      flush;
    fwdSel_t   fwdSelA0;
    fwdSel_t   fwdSelB0;
    fwdSel_t   fwdSelA1;
    fwdSel_t   fwdSelB1;
    logic      aluWe;
    regIdx_t   aluRd;
    word_t     aluResult;
    logic      branchTaken;
    imemAddr_t branchTarget;
    logic      memWe;
    regIdx_t   memRd;
    word_t     loadData;

    bundleFetch fetch0 (
        .clk(clk), .rstn(rstn), .run(run), .stall(stallFront), .flush(flush),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .bundle(fdBundle), .bundlePc(fdPc)
    );

    // slot 0 writes from memory, slot 1 loads from writeback
    bundleDecode decode0 (
        .clk(clk), .rstn(rstn), .bundle(fdBundle), .bundlePc(fdPc),
        .stall(stallFront), .stallEx(stallEx), .flush(flush),
        .we0(aluWe), .waddr0(aluRd), .wdata0(aluResult),
        .we1(memWe), .waddr1(memRd), .wdata1(loadData),
        .exOp0(exOp0), .exRs0(exRs0), .exRt0(exRt0), .exDst0(exDst0),
        .exImm0(exImm0), .exA0(exA0), .exB0(exB0),
        .exOp1(exOp1), .exRs1(exRs1), .exRt1(exRt1), .exDst1(exDst1),
        .exImm1(exImm1), .exA1(exA1), .exB1(exB1), .exPc(exPc)
    );

    hazardUnit hazard0 (
        .decRs0(fdBundle[rsMsb:rsLsb]), .decRt0(fdBundle[rtMsb:rtLsb]),
        .decRs1(fdBundle[slotWidth+rsMsb:slotWidth+rsLsb]),
        .decRt1(fdBundle[slotWidth+rtMsb:slotWidth+rtLsb]),
        .exOp0(exOp0), .exRs0(exRs0), .exRt0(exRt0),
        .exOp1(exOp1), .exRs1(exRs1), .exRt1(exRt1), .exDst1(exDst1),
        .aluWe(aluWe), .aluRd(aluRd), .memWe(memWe), .memRd(memRd),
        .outValid(outValid), .outReady(outReady), .branchTaken(branchTaken),
        .stallFront(stallFront), .stallEx(stallEx), .flush(flush),
        .fwdSelA0(fwdSelA0), .fwdSelB0(fwdSelB0),
        .fwdSelA1(fwdSelA1), .fwdSelB1(fwdSelB1)
    );

    aluSlot alu0 (
        .clk(clk), .rstn(rstn), .exOp(exOp0), .exDst(exDst0), .exImm(exImm0),
        .exA(exA0), .exB(exB0), .exPc(exPc), .fwdSelA(fwdSelA0), .fwdSelB(fwdSelB0),
        .loadData(loadData), .stall(stallEx), .outReady(outReady),
        .aluWe(aluWe), .aluRd(aluRd), .aluResult(aluResult),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .outValid(outValid), .outData(outData)
    );

    memSlot mem0 (
        .clk(clk), .rstn(rstn), .exOp(exOp1), .exDst(exDst1), .exImm(exImm1),
        .exA(exA1), .exB(exB1), .fwdSelA(fwdSelA1), .fwdSelB(fwdSelB1),
        .aluResult(aluResult), .stall(stallEx),
        .memWe(memWe), .memRd(memRd), .loadData(loadData)
    );

endmodule

//--- tbVliw.sv
`timescale 1ns/1ps

module tbVliw
    import vliwPkg::*;
();

    localparam word_t marker = 32'h00007bad;
    localparam int runLimit = 2000;
    localparam int drainCycles = 50;
    localparam slot_t nopSlot = '0;

    logic      clk;
    logic      rstn;
    logic      imemWe;
    imemAddr_t imemAddr;
    bundle_t   imemData;
    logic      run;
    logic      outValid;
    word_t     outData;
    logic      outReady;

    bundle_t     prog [256];
    int          progLen;
    word_t       expected [$];
    int          gotCount;
    int          mismatchCount;
    int          otherCount;
    logic [31:0] lfsrState;
    logic        holdPrev;
    word_t       dataPrev;

    vliwCore dut0 (
        .clk(clk), .rstn(rstn), .imemWe(imemWe), .imemAddr(imemAddr),
        .imemData(imemData), .run(run), .outValid(outValid), .outData(outData),
        .outReady(outReady)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function logic [31:0] takeBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic slot_t rSlot(opcode_t op, regIdx_t rs, regIdx_t rt, regIdx_t rd);
        return {op, rs, rt, rd, 11'd0};
    endfunction

    function automatic slot_t iSlot(opcode_t op, regIdx_t rs, regIdx_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addBundle(slot_t s0, slot_t s1);
        prog[progLen] = {s1, s0};
        progLen++;
    endtask

    task automatic buildProgram();
        logic [15:0] c1;
        logic [15:0] c2;
        logic [15:0] c3;
        c1 = 16'(takeBits(16));
        c2 = 16'(takeBits(16));
        c3 = 16'(takeBits(16));
        // unused words jump to themselves
        for (int a = 0; a < 256; a++) begin
            prog[a] = {nopSlot, iSlot(OP_J, 0, 0, 16'(a))};
        end
        progLen = 0;
        addBundle(iSlot(OP_ADDI, 0, 15, marker[15:0]), nopSlot);
        addBundle(iSlot(OP_ADDI, 0, 1, c1), nopSlot);
        addBundle(iSlot(OP_ADDI, 1, 2, c2), nopSlot);
        addBundle(rSlot(OP_ADD, 1, 2, 3), nopSlot);
        addBundle(rSlot(OP_SUB, 3, 1, 4), nopSlot);
        addBundle(rSlot(OP_OUT, 3, 0, 0), nopSlot);
        addBundle(rSlot(OP_AND, 4, 1, 5), nopSlot);
        addBundle(rSlot(OP_OR, 5, 3, 6), nopSlot);
        addBundle(rSlot(OP_OUT, 6, 0, 0), nopSlot);
        // store, load, then use in the next bundle
        addBundle(rSlot(OP_OUT, 4, 0, 0), iSlot(OP_SW, 0, 6, 4));
        addBundle(iSlot(OP_ADDI, 0, 7, 1), iSlot(OP_LW, 0, 8, 4));
        addBundle(rSlot(OP_ADD, 8, 7, 9), nopSlot);
        addBundle(rSlot(OP_OUT, 9, 0, 0), nopSlot);
        // both slots share registers within a bundle
        addBundle(rSlot(OP_ADD, 1, 7, 10), iSlot(OP_LW, 7, 1, 3));
        addBundle(iSlot(OP_ADDI, 7, 7, 5), iSlot(OP_SW, 7, 7, 8));
        addBundle(rSlot(OP_OUT, 10, 0, 0), nopSlot);
        addBundle(rSlot(OP_OUT, 1, 0, 0), nopSlot);
        addBundle(rSlot(OP_OUT, 7, 0, 0), iSlot(OP_LW, 0, 13, 9));
        addBundle(rSlot(OP_OUT, 13, 0, 0), nopSlot);
        // taken branch over two OUTs
        addBundle(iSlot(OP_BEQ, 1, 6, 2), nopSlot);
        addBundle(rSlot(OP_OUT, 15, 0, 0), nopSlot);
        addBundle(rSlot(OP_OUT, 15, 0, 0), nopSlot);
        addBundle(iSlot(OP_BEQ, 1, 2, 1), nopSlot);
        addBundle(rSlot(OP_OUT, 13, 0, 0), nopSlot);
        addBundle(iSlot(OP_J, 0, 0, 16'(progLen + 3)), nopSlot);
        addBundle(rSlot(OP_OUT, 15, 0, 0), nopSlot);
        addBundle(rSlot(OP_OUT, 15, 0, 0), nopSlot);
        addBundle(rSlot(OP_OUT, 5, 0, 0), nopSlot);
        addBundle(iSlot(OP_ADDI, 4, 16, c3), nopSlot);
        addBundle(rSlot(OP_OUT, 16, 0, 0), nopSlot);
        addBundle(rSlot(OP_ADD, 16, 16, 17), nopSlot);
        addBundle(rSlot(OP_OUT, 17, 0, 0), nopSlot);
        addBundle(rSlot(OP_OUT, 1, 0, 0), nopSlot);
        addBundle(rSlot(OP_OUT, 2, 0, 0), nopSlot);
        addBundle(iSlot(OP_J, 0, 0, 16'(progLen)), nopSlot);
    endtask

    // sequential ISA model stepping one bundle at a time
    task automatic runModel();
        word_t     mReg [32];
        word_t     mMem [256];
        imemAddr_t pc;
        imemAddr_t nextPc;
        slot_t     s0;
        slot_t     s1;
        word_t     a0;
        word_t     b0;
        word_t     a1;
        word_t     b1;
        word_t     imm0;
        word_t     imm1;
        word_t     w0;
        word_t     w1;
        word_t     addr1;
        regIdx_t   d0;
        regIdx_t   d1;
        logic      we0;
        logic      we1;
        logic      done;
        int        steps;
        for (int i = 0; i < 32; i++) begin
            mReg[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mMem[i] = '0;
        end
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            s0 = prog[pc][31:0];
            s1 = prog[pc][63:32];
            imm0 = {{16{s0[15]}}, s0[15:0]};
            imm1 = {{16{s1[15]}}, s1[15:0]};
            a0 = mReg[s0[25:21]];
            b0 = mReg[s0[20:16]];
            a1 = mReg[s1[25:21]];
            b1 = mReg[s1[20:16]];
            addr1 = a1 + imm1;
            w0 = '0;
            w1 = '0;
            we0 = 1'b0;
            we1 = 1'b0;
            d0 = s0[15:11];
            d1 = s1[20:16];
            nextPc = pc + 8'd1;
            case (opcode_t'(s0[31:26]))
                OP_ADD: begin
                    w0 = a0 + b0;
                    we0 = 1'b1;
                end
                OP_SUB: begin
                    w0 = a0 - b0;
                    we0 = 1'b1;
                end
                OP_AND: begin
                    w0 = a0 & b0;
                    we0 = 1'b1;
                end
                OP_OR: begin
                    w0 = a0 | b0;
                    we0 = 1'b1;
                end
                OP_ADDI: begin
                    w0 = a0 + imm0;
                    we0 = 1'b1;
                    d0 = s0[20:16];
                end
                OP_BEQ: begin
                    if (a0 == b0) begin
                        nextPc = pc + 8'd1 + imm0[7:0];
                    end
                end
                OP_J: begin
                    nextPc = imm0[7:0];
                    done = nextPc == pc;
                end
                OP_OUT: expected.push_back(a0);
                default: ;
            endcase
            case (opcode_t'(s1[31:26]))
                OP_LW: begin
                    w1 = mMem[addr1[7:0]];
                    we1 = 1'b1;
                end
                OP_SW: mMem[addr1[7:0]] = b1;
                default: ;
            endcase
            if (we0 && d0 != 0) begin
                mReg[d0] = w0;
            end
            if (we1 && d1 != 0) begin
                mReg[d1] = w1;
            end
            pc = nextPc;
            steps++;
        end
        if (!done) begin
            otherCount++;
            $display("model never reached the final self jump");
        end
    endtask

    always @(negedge clk) begin
        outReady <= takeBits(1) != '0;
    end

    always @(posedge clk) begin
        if (rstn && !run) begin
            assert (!outValid) else begin
                mismatchCount++;
                $display("Mismatch at %0t: outValid high while run is low", $time);
            end
        end
        if (rstn && holdPrev) begin
            assert (outValid && outData == dataPrev) else begin
                mismatchCount++;
                $display("Mismatch at %0t: output word %h changed to %h while stalled",
                         $time, dataPrev, outData);
            end
        end
        if (rstn && outValid && outReady) begin
            if (gotCount >= expected.size()) begin
                otherCount++;
                $display("extra output word %h at %0t after all %0d expected words",
                         outData, $time, expected.size());
            end else begin
                assert (outData == expected[gotCount]) else begin
                    mismatchCount++;
                    $display("Mismatch at %0t: word %0d is %h, model gives %h",
                             $time, gotCount, outData, expected[gotCount]);
                end
            end
            assert (outData != marker) else begin
                mismatchCount++;
                $display("Mismatch at %0t: word from a discarded bundle", $time);
            end
            gotCount++;
        end
        holdPrev = rstn && outValid && !outReady;
        dataPrev = outData;
    end

    initial begin
        int cycles;
        rstn = 1'b0;
        run = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        outReady = 1'b0;
        lfsrState = 32'h8c5617e9;
        mismatchCount = 0;
        otherCount = 0;
        gotCount = 0;
        holdPrev = 1'b0;
        dataPrev = '0;
        buildProgram();
        runModel();
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        // program load with fetch idle
        for (int a = 0; a < 256; a++) begin
            imemWe = 1'b1;
            imemAddr = imemAddr_t'(a);
            imemData = prog[a];
            @(negedge clk);
        end
        imemWe = 1'b0;
        repeat (8) @(negedge clk);
        run = 1'b1;
        cycles = 0;
        while (gotCount < expected.size() && cycles < runLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (gotCount < expected.size()) begin
            otherCount++;
            $display("timeout: only %0d of %0d output words arrived in %0d cycles",
                     gotCount, expected.size(), cycles);
        end
        // catch late extra words
        repeat (drainCycles) @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- sim.f
vliwPkg.sv
regFile.sv
bundleFetch.sv
bundleDecode.sv
hazardUnit.sv
aluSlot.sv
memSlot.sv
vliwCore.sv
tbVliw.sv

//--- Bender.yml
package:
  name: vliwCore

sources:
  - vliwPkg.sv
  - regFile.sv
  - bundleFetch.sv
  - bundleDecode.sv
  - hazardUnit.sv
  - aluSlot.sv
  - memSlot.sv
  - vliwCore.sv
  - target: test
    files:
      - tbVliw.sv
